// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Isource
TOP       ?= xbar_tb
FILELIST  ?= project.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/xbar_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_checker (
  input  logic                                   sclk,
  input  logic                                   reset,
  input  xbar_pkg::wb_req_t                      host_req,
  input  xbar_pkg::wb_rsp_t                      host_rsp,
  input  xbar_pkg::xbar_line_t [`XBAR_COUNT-1:0] xbar,
  input  logic                                   exp_chk,     // compare next read with exp_dat
  input  logic [31:0]                            exp_dat,
  input  logic                                   pulse_chk,   // one-cycle strobe
  input  logic [8*`XBAR_COUNT-1:0]               exp_pulses,  // 8 bits per crossbar
  output int                                     read_errs,
  output int                                     stream_errs,
  output int                                     pulse_errs
);

  localparam int NWORDS = `XBAR_COUNT * `XBAR_WORDS;
  localparam int NBITS  = `XBAR_WORDS * 32;

  logic [31:0]       model [NWORDS];        // what the config ram should hold
  xbar_pkg::wb_req_t held_req;              // last request seen with stb
  logic              held_chk;
  logic [31:0]       held_exp;
  logic [NBITS-1:0]  stream [`XBAR_COUNT];  // word 0 msb lands in the top bit
  int                nbits [`XBAR_COUNT];
  int                pulses [`XBAR_COUNT];
  logic              prev_clk [`XBAR_COUNT];

  initial begin
    for (int w = 0; w < NWORDS; w++)
      model[w] = 32'h0;
  end

  // host offsets 0..31 on the host page go to the ram
  function automatic logic is_cfg(input logic [15:0] adr);
    return (adr[15:8] == `XBAR_HOST_PAGE) && (adr[7:0] < 8'(NWORDS));
  endfunction

  // id and busy reads come from registers, not from the ram
  function automatic logic is_status(input logic [15:0] adr);
    return (adr[15:8] == `XBAR_HOST_PAGE) &&
           (adr[7:0] == `XBAR_OFS_ID || adr[7:0] == `XBAR_OFS_BUSY);
  endfunction

  // compare one latched stream with its half of the model
  task automatic check_stream(input int k);
    logic [31:0] got;
    logic [31:0] want;
    if (nbits[k] != NBITS) begin
      $display("crossbar %0d latched after %0d clock pulses instead of %0d at %0t",
               k, nbits[k], NBITS, $time);
      stream_errs++;
    end else begin
      for (int w = 0; w < `XBAR_WORDS; w++) begin
        got  = stream[k][NBITS-1-32*w -: 32];
        want = model[k*`XBAR_WORDS + w];
        if (got !== want) begin
          $display("FAIL %0t xbar[%0d].sin word %0d expected %h got %h", $time, k, w, want, got);
          stream_errs++;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // everything sampled on the rising sclk, inputs settled since the falling edge
  // --------------------------------------------------------------------------
  always @(posedge sclk) begin
    if (reset) begin
      held_req    = '0;
      held_chk    = 1'b0;
      held_exp    = 32'h0;
      read_errs   = 0;
      stream_errs = 0;
      pulse_errs  = 0;
      for (int k = 0; k < `XBAR_COUNT; k++) begin
        nbits[k]    = 0;
        pulses[k]   = 0;
        prev_clk[k] = 1'b0;
      end
    end else begin
      // ack arrives after the host has dropped stb, so use the held request
      if (host_rsp.ack) begin
        if (held_req.we) begin
          if (is_cfg(held_req.adr))
            model[held_req.adr[4:0]] = held_req.dat;
        end else begin
          if (held_chk && host_rsp.dat !== held_exp) begin
            $display("FAIL %0t host_rsp.dat adr %h expected %h got %h",
                     $time, held_req.adr, held_exp, host_rsp.dat);
            read_errs++;
          end
          if (is_cfg(held_req.adr) && !is_status(held_req.adr) &&
              host_rsp.dat !== model[held_req.adr[4:0]]) begin
            $display("FAIL %0t host_rsp.dat adr %h model %h got %h",
                     $time, held_req.adr, model[held_req.adr[4:0]], host_rsp.dat);
            read_errs++;
          end
        end
      end
      if (host_req.cyc && host_req.stb) begin
        held_req = host_req;
        held_chk = exp_chk;
        held_exp = exp_dat;
      end

      for (int k = 0; k < `XBAR_COUNT; k++) begin
        if (xbar[k].clk && !prev_clk[k]) begin   // receiver samples on the rise
          if (nbits[k] < NBITS)
            stream[k][NBITS-1-nbits[k]] = xbar[k].sin;
          nbits[k]++;
        end
        prev_clk[k] = xbar[k].clk;
        if (!xbar[k].pclk) begin                 // latch pulse, one cycle low
          pulses[k]++;
          check_stream(k);
          nbits[k] = 0;
        end
      end

      if (pulse_chk) begin
        for (int k = 0; k < `XBAR_COUNT; k++) begin
          if (pulses[k] != int'(exp_pulses[8*k +: 8])) begin
            $display("FAIL %0t xbar[%0d].pclk pulse count expected %0d got %0d",
                     $time, k, int'(exp_pulses[8*k +: 8]), pulses[k]);
            pulse_errs++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/xbar_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_tb;

  localparam int MAX_CYCLES = 8000;   // ~6 full programmings plus host traffic

  typedef enum logic [1:0] {op_write, op_read, op_idle} op_t;

  // one row of the stimulus table
  typedef struct packed {
    op_t         op;
    logic [15:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;   // read value, or pulse counts for op_idle
  } step_t;

  logic                                   sclk = 1'b0;
  logic                                   reset;
  xbar_pkg::wb_req_t                      host_req;
  xbar_pkg::wb_rsp_t                      host_rsp;
  xbar_pkg::xbar_line_t [`XBAR_COUNT-1:0] xbar;
  logic                                   exp_chk;
  logic [31:0]                            exp_dat;
  logic                                   pulse_chk;
  logic [8*`XBAR_COUNT-1:0]               exp_pulses;
  int                                     read_errs;
  int                                     stream_errs;
  int                                     pulse_errs;
  int                                     cycles = 0;
  step_t                                  steps [$];
  logic [31:0]                            words [32];   // random config data

  always #20 sclk = ~sclk;   // 40 ns period

  xbar_subsystem xbar_subsystem_inst (
    .sclk     (sclk),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .xbar     (xbar)
  );

  xbar_checker checker_inst (
    .sclk        (sclk),
    .reset       (reset),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .xbar        (xbar),
    .exp_chk     (exp_chk),
    .exp_dat     (exp_dat),
    .pulse_chk   (pulse_chk),
    .exp_pulses  (exp_pulses),
    .read_errs   (read_errs),
    .stream_errs (stream_errs),
    .pulse_errs  (pulse_errs)
  );

  function automatic logic [15:0] host_adr(input logic [7:0] ofs);
    return {`XBAR_HOST_PAGE, ofs};
  endfunction

  function automatic logic [31:0] pulse_pair(input int c0, input int c1);
    return {16'h0000, 8'(c1), 8'(c0)};
  endfunction

  task automatic add_step(input op_t op, input logic [15:0] adr, input logic [31:0] dat,
                          input logic [31:0] exp);
    step_t s;
    s.op  = op;
    s.adr = adr;
    s.dat = dat;
    s.exp = exp;
    steps.push_back(s);
  endtask

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    add_step(op_read, host_adr(`XBAR_OFS_ID), 32'h0, 32'(`XBAR_ID_VALUE));
    add_step(op_read, host_adr(`XBAR_OFS_BUSY), 32'h0, 32'h0);
    add_step(op_read, 16'h0109, 32'h0, 32'h0);            // id offset on a foreign page
    add_step(op_read, host_adr(8'h40), 32'h0, 32'h0);     // unused offset
    add_step(op_read, host_adr(`XBAR_OFS_CMD), 32'h0, 32'h0);
    for (int w = 0; w < 32; w++) begin
      words[w] = $urandom;
      add_step(op_write, host_adr(8'(w)), words[w], 32'h0);
    end
    for (int w = 0; w < 32; w++) begin
      if (8'(w) == `XBAR_OFS_ID)          // id read shadows this word
        add_step(op_read, host_adr(8'(w)), 32'h0, 32'(`XBAR_ID_VALUE));
      else if (8'(w) == `XBAR_OFS_BUSY)   // busy read, all idle here
        add_step(op_read, host_adr(8'(w)), 32'h0, 32'h0);
      else
        add_step(op_read, host_adr(8'(w)), 32'h0, words[w]);
    end
    // crossbar 0 alone
    add_step(op_write, host_adr(`XBAR_OFS_CMD), 32'h1, 32'h0);
    add_step(op_idle, 16'h0, 32'h0, pulse_pair(1, 0));
    // both at once, host keeps the bus busy meanwhile
    add_step(op_write, host_adr(`XBAR_OFS_CMD), 32'h3, 32'h0);
    for (int i = 0; i < 6; i++) begin
      add_step(op_read, host_adr(`XBAR_OFS_ID), 32'h0, 32'(`XBAR_ID_VALUE));
      add_step(op_read, host_adr(8'(i * 5 + 1)), 32'h0, words[i * 5 + 1]);
    end
    add_step(op_idle, 16'h0, 32'h0, pulse_pair(2, 1));
    // second start while busy is dropped
    add_step(op_write, host_adr(`XBAR_OFS_CMD), 32'h1, 32'h0);
    add_step(op_write, host_adr(`XBAR_OFS_CMD), 32'h1, 32'h0);
    add_step(op_idle, 16'h0, 32'h0, pulse_pair(3, 1));
    // fresh data for crossbar 1
    for (int w = 16; w < 32; w++) begin
      words[w] = $urandom;
      add_step(op_write, host_adr(8'(w)), words[w], 32'h0);
      add_step(op_read, host_adr(8'(w)), 32'h0, words[w]);
    end
    add_step(op_write, host_adr(`XBAR_OFS_CMD), 32'h2, 32'h0);
    add_step(op_idle, 16'h0, 32'h0, pulse_pair(3, 2));
  endtask

  // one wishbone classic access, driven on falling edges
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                            input logic chk, input logic [31:0] exp,
                            output logic [31:0] rdat);
    @(negedge sclk);
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = dat;
    exp_chk      = chk;
    exp_dat      = exp;
    do
      @(negedge sclk);
    while (!host_rsp.ack);
    rdat     = host_rsp.dat;
    host_req = '0;          // stb drops in the cycle after ack
    exp_chk  = 1'b0;
  endtask

  // poll busy until all crossbars are idle, then have the pulse counts compared
  task automatic wait_idle(input logic [31:0] counts);
    logic [31:0] rdat;
    rdat = 32'hffff_ffff;
    while (rdat[`XBAR_COUNT-1:0] != '0)
      bus_access(1'b0, host_adr(`XBAR_OFS_BUSY), 32'h0, 1'b0, 32'h0, rdat);
    @(negedge sclk);
    exp_pulses = counts[8*`XBAR_COUNT-1:0];
    pulse_chk  = 1'b1;
    @(negedge sclk);
    pulse_chk  = 1'b0;
  endtask

  initial begin
    step_t       s;
    logic [31:0] rdat;
    host_req   = '0;
    reset      = 1'b1;
    exp_chk    = 1'b0;
    exp_dat    = 32'h0;
    pulse_chk  = 1'b0;
    exp_pulses = '0;
    void'($urandom(32'h07b2_2564));
    build_table();
    repeat (16) @(posedge sclk);
    @(negedge sclk);
    reset = 1'b0;
    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        op_write: bus_access(1'b1, s.adr, s.dat, 1'b0, 32'h0, rdat);
        op_read:  bus_access(1'b0, s.adr, 32'h0, 1'b1, s.exp, rdat);
        default:  wait_idle(s.exp);
      endcase
    end
    repeat (4) @(negedge sclk);
    $display("error counts: read %0d, stream %0d, pulse %0d", read_errs, stream_errs, pulse_errs);
    if (read_errs + stream_errs + pulse_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------
  always @(posedge sclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run hung, the table was not finished after %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/xbar_pkg.sv
source/xbar_host_regs.sv
source/wb_arbiter.sv
source/xbar_config_ram.sv
source/xbar_shifter.sv
source/xbar_subsystem.sv
dv/xbar_checker.sv
dv/xbar_tb.sv

// ==== source/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
  parameter int NUM_MASTERS = 3
) (
  input  logic                                sclk,
  input  logic                                reset,
  input  xbar_pkg::wb_req_t [NUM_MASTERS-1:0] m_req,
  output xbar_pkg::wb_rsp_t [NUM_MASTERS-1:0] m_rsp,
  output xbar_pkg::wb_req_t                   s_req,
  input  xbar_pkg::wb_rsp_t                   s_rsp
);

  localparam int IW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  logic          gnt_valid;
  logic [IW-1:0] gnt_idx;     // owner of the slave while gnt_valid
  logic [IW-1:0] last_idx;    // last owner, lowest priority next round
  logic [IW-1:0] next_idx;
  logic          next_found;

  // round robin search, starting just after the last owner
  always_comb begin : pick
    int cand;
    next_idx   = last_idx;
    next_found = 1'b0;
    for (int i = 1; i <= NUM_MASTERS; i++) begin
      cand = int'(last_idx) + i;
      if (cand >= NUM_MASTERS)
        cand = cand - NUM_MASTERS;   // wrap
      if (!next_found && m_req[cand].cyc) begin
        next_found = 1'b1;
        next_idx   = IW'(cand);
      end
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      gnt_valid <= 1'b0;
      gnt_idx   <= '0;
      last_idx  <= IW'(NUM_MASTERS - 1);   // master 0 goes first
    end else if (!gnt_valid) begin
      gnt_valid <= next_found;
      gnt_idx   <= next_idx;
    end else if (!m_req[gnt_idx].cyc) begin
      gnt_valid <= 1'b0;                   // cycle done, rotate
      last_idx  <= gnt_idx;
    end
  end

  // ---------------------------------------------------------------------------
  // data path
  // ---------------------------------------------------------------------------
  assign s_req = gnt_valid ? m_req[gnt_idx] : '0;

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_rsp[i] = '0;   // no ack is the back-pressure for losers
      if (gnt_valid && gnt_idx == IW'(i))
        m_rsp[i] = s_rsp;
    end
  end

endmodule

`default_nettype wire

// ==== source/xbar_config.svh ====
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// ---------------------------------------------------------------------------
// crossbar array geometry
// ---------------------------------------------------------------------------
`define XBAR_COUNT      2         // analog crossbar arrays
`define XBAR_WORDS      16        // 32-bit config words per crossbar (512 bits)

// ---------------------------------------------------------------------------
// host address map, page in adr[15:8] and offset in adr[7:0]
// ---------------------------------------------------------------------------
`define XBAR_HOST_PAGE  8'h00
`define XBAR_OFS_CMD    8'h20     // start bits, one per crossbar
`define XBAR_OFS_ID     8'h09
`define XBAR_OFS_BUSY   8'h0A
`define XBAR_ID_VALUE   16'h7ba2  // read back zero-extended

`endif

// ==== source/xbar_config_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_config_ram (
  input  logic              sclk,
  input  logic              reset,
  input  xbar_pkg::wb_req_t bus_req,
  output xbar_pkg::wb_rsp_t bus_rsp
);

  localparam int DEPTH = `XBAR_COUNT * `XBAR_WORDS;   // 32 words
  localparam int AW    = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] addr;
  logic          hit;     // new access, not the tail of the last one
  logic          ack_q;
  logic [31:0]   rd_q;

  assign addr = bus_req.adr[AW-1:0];
  assign hit  = bus_req.cyc && bus_req.stb && !ack_q;

  always_ff @(posedge sclk) begin
    if (reset)
      ack_q <= 1'b0;
    else
      ack_q <= hit;
  end

  always_ff @(posedge sclk) begin
    if (hit) begin
      if (bus_req.we)
        mem[addr] <= bus_req.dat;
      rd_q <= mem[addr];   // old word on a write, nobody reads it then
    end
  end

  assign bus_rsp.ack = ack_q;
  assign bus_rsp.dat = rd_q;

endmodule

`default_nettype wire

// ==== source/xbar_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_host_regs (
  input  logic                   sclk,
  input  logic                   reset,
  input  xbar_pkg::wb_req_t      host_req,
  output xbar_pkg::wb_rsp_t      host_rsp,
  output xbar_pkg::wb_req_t      mem_req,
  input  xbar_pkg::wb_rsp_t      mem_rsp,
  input  logic [`XBAR_COUNT-1:0] busy,
  output logic [`XBAR_COUNT-1:0] start
);

  logic [7:0]  page;      // host adr[15:8]
  logic [7:0]  ofs;       // host adr[7:0]
  logic        page_hit;
  logic        stat_rd;   // id or busy read, shadows the ram word at that offset
  logic        cfg_sel;   // access targets the config ram
  logic        reg_sel;   // new local register access this cycle
  logic        reg_ack;
  logic [31:0] reg_dat;
  logic [31:0] rd_mux;

  assign page     = host_req.adr[15:8];
  assign ofs      = host_req.adr[7:0];
  assign page_hit = (page == `XBAR_HOST_PAGE);
  assign stat_rd  = page_hit && !host_req.we &&
                    (ofs == `XBAR_OFS_ID || ofs == `XBAR_OFS_BUSY);
  assign cfg_sel  = page_hit && (ofs < 8'(`XBAR_COUNT * `XBAR_WORDS)) && !stat_rd;
  // anything not on the ram window is answered here, pending ack blocks a repeat
  assign reg_sel  = host_req.cyc && host_req.stb && !cfg_sel && !reg_ack;

  // ---------------------------------------------------------------------------
  // config window, relayed to the arbiter and held by the host until ack
  // ---------------------------------------------------------------------------
  always_comb begin
    mem_req     = host_req;
    mem_req.cyc = host_req.cyc & cfg_sel;
    mem_req.stb = host_req.stb & cfg_sel;
  end

  // local read data, unmapped offsets and foreign pages read 0
  always_comb begin
    rd_mux = '0;
    if (page_hit) begin
      case (ofs)
        `XBAR_OFS_ID:   rd_mux = 32'(`XBAR_ID_VALUE);
        `XBAR_OFS_BUSY: rd_mux = 32'(busy);          // busy bits in the low end
        default:        rd_mux = '0;                 // cmd reads back 0 too
      endcase
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      reg_ack <= 1'b0;
      start   <= '0;
    end else begin
      reg_ack <= reg_sel;
      // one-cycle start, a request for a busy crossbar is dropped
      if (reg_sel && host_req.we && page_hit && ofs == `XBAR_OFS_CMD)
        start <= host_req.dat[`XBAR_COUNT-1:0] & ~busy;
      else
        start <= '0;
    end
  end

  always_ff @(posedge sclk) begin
    if (reg_sel)
      reg_dat <= rd_mux;
  end

  // ram acks only reach us for config accesses, so an or is enough
  assign host_rsp.ack = reg_ack | mem_rsp.ack;
  assign host_rsp.dat = reg_ack ? reg_dat : mem_rsp.dat;

endmodule

`default_nettype wire

// ==== source/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

  // ---------------------------------------------------------------------------
  // wishbone classic, single width, no byte selects
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;   // page in 15:8, offset in 7:0
    logic [31:0] dat;   // write data
  } wb_req_t;

  typedef struct packed {
    logic        ack;   // one cycle per access
    logic [31:0] dat;   // read data, valid with ack
  } wb_rsp_t;

  // ---------------------------------------------------------------------------
  // pins toward one crossbar array
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic clk;    // shift clock, receiver samples sin on rise
    logic pclk;   // latch, active low
    logic sin;    // serial data, msb first
  } xbar_line_t;

endpackage

`default_nettype wire

// ==== source/xbar_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_shifter #(
  parameter int XBAR_INDEX = 0   // picks the ram half
) (
  input  logic                 sclk,
  input  logic                 reset,
  input  logic                 start,
  output logic                 busy,
  output xbar_pkg::wb_req_t    mem_req,
  input  xbar_pkg::wb_rsp_t    mem_rsp,
  output xbar_pkg::xbar_line_t line
);

  localparam int NBITS = `XBAR_WORDS * 32;   // 512 bits per array

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,       // read one word over the bus
    st_shift_low,   // sin settles, clk low
    st_shift_high,  // clk high, receiver samples
    st_latch        // pclk low for one cycle
  } state_t;

  state_t      state;
  logic [8:0]  bit_cnt;   // bits already sent
  logic [31:0] sreg;      // current word, bit 31 on the line

  // ---------------------------------------------------------------------------
  // fsm and data path
  // ---------------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
      sreg    <= '0;
    end else begin
      case (state)
        st_idle: begin
          bit_cnt <= '0;
          if (start)
            state <= st_fetch;
        end
        st_fetch: begin
          if (mem_rsp.ack) begin
            sreg  <= mem_rsp.dat;
            state <= st_shift_low;
          end
        end
        st_shift_low: state <= st_shift_high;
        st_shift_high: begin
          sreg    <= {sreg[30:0], 1'b0};   // next bit after the high phase
          bit_cnt <= bit_cnt + 9'd1;
          if (bit_cnt == 9'(NBITS - 1))
            state <= st_latch;
          else if (bit_cnt[4:0] == 5'h1f)
            state <= st_fetch;             // word done, get the next one
          else
            state <= st_shift_low;
        end
        st_latch: state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  assign busy = (state != st_idle);   // rises the cycle after start

  // ---------------------------------------------------------------------------
  // bus read, word index comes from the upper counter bits
  // ---------------------------------------------------------------------------
  always_comb begin
    mem_req     = '0;
    mem_req.cyc = (state == st_fetch);
    mem_req.stb = (state == st_fetch);   // drops once ack moves us on
    mem_req.adr = 16'(XBAR_INDEX * `XBAR_WORDS) + 16'(bit_cnt[8:5]);
  end

  // crossbar pins
  assign line.clk  = (state == st_shift_high);
  assign line.pclk = (state != st_latch);    // idle high
  assign line.sin  = sreg[31];

endmodule

`default_nettype wire

// ==== source/xbar_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module xbar_subsystem (
  input  logic                                     sclk,
  input  logic                                     reset,
  input  xbar_pkg::wb_req_t                        host_req,
  output xbar_pkg::wb_rsp_t                        host_rsp,
  output xbar_pkg::xbar_line_t [`XBAR_COUNT-1:0]   xbar
);

  localparam int NUM_MASTERS = `XBAR_COUNT + 1;   // host regs plus one per shifter

  xbar_pkg::wb_req_t [NUM_MASTERS-1:0] arb_req;   // 0 host, k+1 shifter k
  xbar_pkg::wb_rsp_t [NUM_MASTERS-1:0] arb_rsp;
  xbar_pkg::wb_req_t                   ram_req;
  xbar_pkg::wb_rsp_t                   ram_rsp;
  logic [`XBAR_COUNT-1:0]              busy;
  logic [`XBAR_COUNT-1:0]              start;

  // ---------------------------------------------------------------------------
  // host side
  // ---------------------------------------------------------------------------
  xbar_host_regs host_regs_inst (
    .sclk     (sclk),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .mem_req  (arb_req[0]),
    .mem_rsp  (arb_rsp[0]),
    .busy     (busy),
    .start    (start)
  );

  wb_arbiter #(
    .NUM_MASTERS (NUM_MASTERS)
  ) arbiter_inst (
    .sclk  (sclk),
    .reset (reset),
    .m_req (arb_req),
    .m_rsp (arb_rsp),
    .s_req (ram_req),
    .s_rsp (ram_rsp)
  );

  xbar_config_ram config_ram_inst (
    .sclk    (sclk),
    .reset   (reset),
    .bus_req (ram_req),
    .bus_rsp (ram_rsp)
  );

  // ---------------------------------------------------------------------------
  // one shifter per crossbar array
  // ---------------------------------------------------------------------------
  for (genvar k = 0; k < `XBAR_COUNT; k++) begin : g_shifter
    xbar_shifter #(
      .XBAR_INDEX (k)
    ) shifter_inst (
      .sclk    (sclk),
      .reset   (reset),
      .start   (start[k]),
      .busy    (busy[k]),
      .mem_req (arb_req[k+1]),
      .mem_rsp (arb_rsp[k+1]),
      .line    (xbar[k])
    );
  end

endmodule

`default_nettype wire
